// ==== car_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module car_layer
(
	input  wire traffic_pkg::coord_t px,
	input  wire traffic_pkg::coord_t py,
	input  wire traffic_pkg::coord_t car_offset [traffic_pkg::NUM_APPROACH][2],
	output logic                     car_hit,
	output traffic_pkg::rgb_t        car_color
);

	import traffic_pkg::*;

	// window test in mod 1024 space, so a car leaving one edge
	// comes back in at the other
	function automatic logic in_box(input coord_t x0, input coord_t y0,
		input coord_t w, input coord_t h);
		in_box = (coord_t'(px - x0) < w) && (coord_t'(py - y0) < h);
	endfunction

	// fixed lane coordinate across the direction of travel
	function automatic coord_t lane_base(input approach_t a, input logic fast);
		if (a == APP_NORTH || a == APP_SOUTH)
			lane_base = fast ? LANE_V_FAST : LANE_V_SLOW;
		else
			lane_base = fast ? LANE_H_FAST : LANE_H_SLOW;
	endfunction

	function automatic rgb_t car_palette(input approach_t a, input logic fast);
		case (a)
			APP_NORTH: car_palette = fast ? COLOR_GREEN : COLOR_WHITE;
			APP_EAST:  car_palette = fast ? COLOR_CYAN  : COLOR_BLUE;
			APP_SOUTH: car_palette = fast ? COLOR_GREEN : COLOR_YELLOW;
			default:   car_palette = fast ? COLOR_RED   : COLOR_MAGENTA;
		endcase
	endfunction

	function automatic logic car_covers(input approach_t a, input logic fast,
		input coord_t o);
		coord_t b;
		b = lane_base(a, fast);
		case (a)
			// north moves up from the bottom edge
			APP_NORTH: car_covers = in_box(H_ACTIVE - b - CAR_SHORT,
				V_ACTIVE - o - CAR_LONG, CAR_SHORT, CAR_LONG);
			APP_EAST:  car_covers = in_box(o, b, CAR_LONG, CAR_SHORT);
			APP_SOUTH: car_covers = in_box(b, o, CAR_SHORT, CAR_LONG);
			// west moves left from the right edge
			default:   car_covers = in_box(H_ACTIVE - o - CAR_LONG,
				V_ACTIVE - b - CAR_SHORT, CAR_LONG, CAR_SHORT);
		endcase
	endfunction

	// ------------------------------------------------------------
	// eight cars, car n is approach n/2, fast when n is odd
	// ------------------------------------------------------------
	always_comb
	begin
		car_hit = 1'b0;
		car_color = COLOR_BLACK;
		// scan downward so the lowest numbered car ends up on top
		for (int n = 7; n >= 0; n--)
		begin
			if (car_covers(approach_t'(n / 2), n[0], car_offset[n / 2][n[0]]))
			begin
				car_hit = 1'b1;
				car_color = car_palette(approach_t'(n / 2), n[0]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== car_motion.sv ====
`timescale 1ns/1ps
`default_nettype none

module car_motion
(
	input  wire                                 dclk,
	input  wire                                 clr,
	input  wire logic                           animate,
	input  wire logic [traffic_pkg::NUM_APPROACH-1:0] light_go,
	output traffic_pkg::coord_t car_offset [traffic_pkg::NUM_APPROACH][2]
);

	import traffic_pkg::*;

	logic anim_q;
	logic anim_edge;

	// where the cars of an approach wait on red
	function automatic coord_t stop_pos(input approach_t a);
		if (a == APP_NORTH || a == APP_SOUTH)
			stop_pos = STOP_VERT;
		else
			stop_pos = STOP_HORIZ;
	endfunction

	// index 0 is the slow car, index 1 the fast one
	function automatic coord_t speed_step(input logic fast);
		if (fast)
			speed_step = STEP_FAST;
		else
			speed_step = STEP_SLOW;
	endfunction

	// ------------------------------------------------------------
	// animate rising edge
	// ------------------------------------------------------------
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
			anim_q <= 1'b0;
		else
			anim_q <= animate;
	end

	assign anim_edge = animate & ~anim_q;

	// ------------------------------------------------------------
	// offsets, one per approach and speed
	// ------------------------------------------------------------
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			for (int a = 0; a < NUM_APPROACH; a++)
			begin
				for (int s = 0; s < 2; s++)
				begin
					car_offset[a][s] <= '0;
				end
			end
		end
		else if (anim_edge)
		begin
			for (int a = 0; a < NUM_APPROACH; a++)
			begin
				for (int s = 0; s < 2; s++)
				begin
					// hold at the stop line while red, wrap at 1024 otherwise
					if (light_go[a] || car_offset[a][s] != stop_pos(approach_t'(a)))
						car_offset[a][s] <= car_offset[a][s] + speed_step(s[0]);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
traffic_pkg.sv
vga_timing.sv
car_motion.sv
car_layer.sv
scene_render.sv
intersection_top.sv
tb_intersection.sv

// ==== intersection_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module intersection_top
(
	input  wire                                        dclk,
	input  wire                                        clr,
	input  wire logic                                  animate,
	input  wire logic [traffic_pkg::NUM_APPROACH-1:0]  light_go,
	output logic                                       hsync,
	output logic                                       vsync,
	output logic [2:0]                                 red,
	output logic [2:0]                                 green,
	output logic [1:0]                                 blue
);

	import traffic_pkg::*;

	wire coord_t px;
	wire coord_t py;
	wire logic   video_on;
	wire logic   hsync_raw;
	wire logic   vsync_raw;
	wire coord_t car_offset [NUM_APPROACH][2];
	wire logic   car_hit;
	wire rgb_t   car_color;
	wire rgb_t   pixel;

	vga_timing timing_i (.dclk(dclk), .clr(clr), .hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw), .video_on(video_on), .px(px), .py(py));

	car_motion motion_i (.dclk(dclk), .clr(clr), .animate(animate),
		.light_go(light_go), .car_offset(car_offset));

	car_layer cars_i (.px(px), .py(py), .car_offset(car_offset),
		.car_hit(car_hit), .car_color(car_color));

	scene_render render_i (.dclk(dclk), .clr(clr), .px(px), .py(py),
		.video_on(video_on), .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
		.light_go(light_go), .car_hit(car_hit), .car_color(car_color),
		.pixel(pixel), .hsync(hsync), .vsync(vsync));

	// 3-3-2 split for the DAC pins
	assign red   = pixel[7:5];
	assign green = pixel[4:2];
	assign blue  = pixel[1:0];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the intersection testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_intersection \
	-o Vtb_intersection \
	-f compile.f

# the testbench stops with a non-zero status on failure, the log decides
./obj_dir/Vtb_intersection 2>&1 | tee "$LOG"

if grep -q 'All tests passed!' "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

// ==== scene_render.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_render
(
	input  wire                       dclk,
	input  wire                       clr,
	input  wire traffic_pkg::coord_t  px,
	input  wire traffic_pkg::coord_t  py,
	input  wire logic                 video_on,
	input  wire logic                 hsync_raw,
	input  wire logic                 vsync_raw,
	input  wire logic [traffic_pkg::NUM_APPROACH-1:0] light_go,
	input  wire logic                 car_hit,
	input  wire traffic_pkg::rgb_t    car_color,
	output traffic_pkg::rgb_t         pixel,
	output logic                      hsync,
	output logic                      vsync
);

	import traffic_pkg::*;

	logic red_on;
	logic red_go;
	logic green_on;
	logic green_go;
	rgb_t pix_next;

	// plain rectangle on the visible area, no wrap
	function automatic logic in_rect(input coord_t x0, input coord_t y0,
		input coord_t w, input coord_t h);
		in_rect = (px >= x0) && (px < x0 + w) && (py >= y0) && (py < y0 + h);
	endfunction

	// yellow centre line pairs, 5 wide with a 6 pixel gap
	function automatic logic double_lines();
		double_lines = in_rect(0, 232, 200, 5) || in_rect(0, 243, 200, 5) ||
			in_rect(440, 232, 200, 5) || in_rect(440, 243, 200, 5) ||
			in_rect(312, 0, 5, 120) || in_rect(323, 0, 5, 120) ||
			in_rect(312, 360, 5, 120) || in_rect(323, 360, 5, 120);
	endfunction

	// six dashes of 20 on a 35 pixel pitch
	function automatic logic h_dashes(input coord_t x0, input coord_t y0);
		logic hit;
		hit = 1'b0;
		for (int k = 0; k < 6; k++)
			hit = hit | in_rect(x0 + coord_t'(35 * k), y0, 20, 5);
		h_dashes = hit;
	endfunction

	function automatic logic v_dashes(input coord_t x0, input coord_t y0);
		logic hit;
		hit = 1'b0;
		for (int k = 0; k < 4; k++)
			hit = hit | in_rect(x0, y0 + coord_t'(35 * k), 5, 20);
		v_dashes = hit;
	endfunction

	// ------------------------------------------------------------
	// lamps
	// ------------------------------------------------------------
	always_comb
	begin
		red_on = 1'b0;
		red_go = 1'b0;
		green_on = 1'b0;
		green_go = 1'b0;
		for (int a = 0; a < NUM_APPROACH; a++)
		begin
			if (in_rect(RED_LAMP_X[a], RED_LAMP_Y[a], LAMP_SIZE, LAMP_SIZE))
			begin
				red_on = 1'b1;
				red_go = light_go[a];
			end
			if (in_rect(GREEN_LAMP_X[a], GREEN_LAMP_Y[a], LAMP_SIZE, LAMP_SIZE))
			begin
				green_on = 1'b1;
				green_go = light_go[a];
			end
		end
	end

	// ------------------------------------------------------------
	// layer priority, small items first
	// ------------------------------------------------------------
	always_comb
	begin
		if (!video_on)
			pix_next = COLOR_BLACK;
		else if (red_on)
			pix_next = red_go ? COLOR_BLACK : COLOR_RED;
		else if (green_on)
			pix_next = green_go ? COLOR_GREEN : COLOR_BLACK;
		else if (in_rect(0, 160, 25, 40) || in_rect(610, 280, 25, 40) ||
			in_rect(360, 0, 40, 25) || in_rect(240, 455, 40, 25))
			pix_next = COLOR_YELLOW;
		else if (car_hit)
			pix_next = car_color;
		else if (in_rect(ROAD_X0, ROAD_Y0, ROAD_WIDTH, ROAD_WIDTH))
			pix_next = COLOR_BLACK;
		else if (double_lines())
			pix_next = COLOR_YELLOW;
		else if (h_dashes(3, 177) || h_dashes(3, 298) || h_dashes(440, 177) ||
			h_dashes(440, 298) || v_dashes(257, 0) || v_dashes(378, 0) ||
			v_dashes(257, 360) || v_dashes(378, 360))
			pix_next = COLOR_WHITE;
		else if (in_rect(0, ROAD_Y0, H_ACTIVE, ROAD_WIDTH))
			pix_next = COLOR_BLACK;
		else if (in_rect(ROAD_X0, 0, ROAD_WIDTH, V_ACTIVE))
			pix_next = COLOR_BLACK;
		else
			pix_next = COLOR_GREEN;
	end

	// sync goes through the same stage as the colour
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			pixel <= COLOR_BLACK;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			pixel <= pix_next;
			hsync <= hsync_raw;
			vsync <= vsync_raw;
		end
	end

endmodule

`default_nettype wire

// ==== tb_intersection.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_intersection;

	import traffic_pkg::*;

	// frames the directed tests need, with margin for frame alignment
	localparam int FRAMES_USED = 12;
	localparam longint FRAME_CLOCKS = 416800;
	localparam longint WATCHDOG_NS = (FRAMES_USED + 2) * FRAME_CLOCKS * 8;

	localparam int RED_LAMP_X [4] = '{363, 615, 262, 5};
	localparam int RED_LAMP_Y [4] = '{5, 283, 460, 182};
	localparam int GREEN_LAMP_X [4] = '{382, 615, 243, 5};
	localparam int GREEN_LAMP_Y [4] = '{5, 302, 460, 163};

	logic dclk;
	logic clr;
	logic animate;
	logic [3:0] light_go;
	wire hsync;
	wire vsync;
	wire [2:0] red;
	wire [2:0] green;
	wire [1:0] blue;
	wire [7:0] pixel_out;

	int error_count = 0;
	int anim_total = 0;
	longint samples [$];

	// raster position shown on the outputs
	int hcnt = 0;
	int vcnt = 0;
	logic hsync_q = 1'b1;
	logic vsync_q = 1'b1;
	logic frame_start = 1'b0;

	intersection_top dut_i (.dclk(dclk), .clr(clr), .animate(animate), .light_go(light_go),
		.hsync(hsync), .vsync(vsync), .red(red), .green(green), .blue(blue));

	assign pixel_out = {red, green, blue};

	initial
	begin
		dclk = 1'b0;
		forever #4 dclk = ~dclk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d frames", FRAMES_USED + 2);
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

	// ------------------------------------------------------------
	// frame tracker, locks on the vsync rise (line 2, column 0)
	// ------------------------------------------------------------
	always
	begin
		@(posedge dclk);
		#2;
		frame_start = !clr && vsync && !vsync_q;
		if (frame_start)
		begin
			hcnt = 0;
			vcnt = 2;
		end
		else
		begin
			if (hcnt == 799)
			begin
				hcnt = 0;
				vcnt = (vcnt == 520) ? 0 : vcnt + 1;
			end
			else
				hcnt = hcnt + 1;
			if (hsync_q && !hsync)
				hcnt = 0;
		end
		hsync_q = hsync;
		vsync_q = vsync;
	end

	task automatic check_value(input string test_name, input longint expected,
		input longint actual);
		if (expected !== actual)
		begin
			error_count++;
			$display("error: %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
			$display("Test failures found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	function automatic logic sync_level(input logic use_v);
		return use_v ? vsync : hsync;
	endfunction

	// low time and period of one sync pulse, counted in clocks
	task automatic measure_sync(input string name, input logic use_v, input int exp_low,
		input int exp_period);
		int low_cnt;
		int period;
		low_cnt = 0;
		period = 0;
		do @(negedge dclk); while (sync_level(use_v) !== 1'b1);
		do @(negedge dclk); while (sync_level(use_v) !== 1'b0);
		while (sync_level(use_v) === 1'b0)
		begin
			low_cnt++;
			period++;
			@(negedge dclk);
		end
		while (sync_level(use_v) === 1'b1)
		begin
			period++;
			@(negedge dclk);
		end
		check_value({name, " low clocks"}, exp_low, low_cnt);
		check_value({name, " period"}, exp_period, period);
	endtask

	task automatic add_position(input int hc, input int vc, input logic [7:0] colour);
		samples.push_back((longint'(vc * 800 + hc) << 8) | colour);
	endtask

	task automatic add_pixel(input int x, input int y, input logic [7:0] colour);
		add_position(x + 144, y + 31, colour);
	endtask

	task automatic wait_frame_start();
		do @(negedge dclk); while (!frame_start);
	endtask

	task automatic wait_position(input int hc, input int vc);
		while (!(hcnt == hc && vcnt == vc))
			@(negedge dclk);
	endtask

	// visit the queued samples in raster order within one frame
	task automatic run_samples(input string name);
		longint key;
		logic [7:0] expected;
		samples.sort();
		wait_frame_start();
		foreach (samples[i])
		begin
			key = samples[i] >> 8;
			expected = samples[i][7:0];
			wait_position(int'(key % 800), int'(key / 800));
			check_value($sformatf("%s at hc %0d vc %0d", name, key % 800, key / 800),
				expected, pixel_out);
		end
		samples.delete();
	endtask

	task automatic drive_lights(input logic [3:0] go);
		@(posedge dclk);
		#1 light_go = go;
	endtask

	task automatic pulse_animate(input int count);
		repeat (count)
		begin
			@(posedge dclk);
			#1 animate = 1'b1;
			@(posedge dclk);
			#1 animate = 1'b0;
		end
		anim_total += count;
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic reset_and_sync_test();
		@(posedge dclk);
		@(negedge dclk);
		check_value("reset hsync", 1, hsync);
		check_value("reset vsync", 1, vsync);
		check_value("reset colour", 0, pixel_out);
		@(posedge dclk);
		#1 clr = 1'b0;
		repeat (3)
			measure_sync("sync_timing hsync", 1'b0, 96, 800);
		measure_sync("sync_timing vsync", 1'b1, 1600, 416800);
	endtask

	task automatic static_scene_test();
		int kind;
		int x;
		int y;
		for (int i = 0; i < 40; i++)
		begin
			kind = $urandom % 5;
			case (kind)
				0:
				begin
					x = $urandom % 200 + (($urandom % 2) * 440);
					y = $urandom % 120 + (($urandom % 2) * 360);
					add_pixel(x, y, COLOR_GREEN);
				end
				1:
				begin
					// road clear of lines, boxes and the parked cars
					x = 60 + $urandom % 140 + (($urandom % 2) * 380);
					y = 120 + $urandom % 55;
					add_pixel(x, y, COLOR_BLACK);
				end
				2:
					add_pixel(200 + $urandom % 240, 120 + $urandom % 240, COLOR_BLACK);
				3:
					add_position($urandom % 144, 2 + $urandom % 519, COLOR_BLACK);
				default:
					add_position($urandom % 800, 2 + $urandom % 29, COLOR_BLACK);
			endcase
		end
		// vertical road above the centre, below the parked south cars
		add_pixel(205, 80, COLOR_BLACK);
		run_samples("static_scene");
	endtask

	task automatic lamp_test(input logic [3:0] go);
		drive_lights(go);
		for (int a = 0; a < 4; a++)
		begin
			for (int d = 0; d < 15; d += 7)
			begin
				add_pixel(RED_LAMP_X[a] + d, RED_LAMP_Y[a] + d, go[a] ? COLOR_BLACK : COLOR_RED);
				add_pixel(GREEN_LAMP_X[a] + d, GREEN_LAMP_Y[a] + d,
					go[a] ? COLOR_GREEN : COLOR_BLACK);
			end
		end
		run_samples($sformatf("lamps go=%b", go));
	endtask

	task automatic car_advance_test(input int n);
		drive_lights(4'b1111);
		pulse_animate(n);
		// east slow offset n, south fast offset 2n
		add_pixel(n + 30, 330, COLOR_BLUE);
		add_pixel(n - 1, 330, COLOR_BLACK);
		add_pixel(230, 2 * n + 30, COLOR_GREEN);
		run_samples($sformatf("car_advance n=%0d", n));
	endtask

	task automatic red_stop_test();
		int west;
		drive_lights(4'b1101);
		// drive the slow east car onto its stop line, then hold it there
		pulse_animate(140 - anim_total);
		pulse_animate(80);
		west = anim_total % 1024;
		add_pixel(170, 330, COLOR_BLUE);
		add_pixel(205, 330, COLOR_BLACK);
		add_pixel(170, 270, COLOR_CYAN);
		add_pixel(640 - west - 30, 150, COLOR_MAGENTA);
		run_samples("red_stop");
	endtask

	initial
	begin
		void'($urandom(40299));
		clr = 1'b1;
		animate = 1'b0;
		light_go = 4'b1111;
		reset_and_sync_test();
		static_scene_test();
		lamp_test(4'b0101);
		lamp_test(4'b1010);
		car_advance_test(1 + $urandom % 24);
		red_stop_test();
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== traffic_pkg.sv ====
`default_nettype none

package traffic_pkg;

	// ------------------------------------------------------------
	// basic types
	// ------------------------------------------------------------
	typedef logic [9:0] coord_t;

	// red [7:5], green [4:2], blue [1:0]
	typedef logic [7:0] rgb_t;

	typedef enum logic [1:0]
	{
		APP_NORTH = 2'd0,
		APP_EAST  = 2'd1,
		APP_SOUTH = 2'd2,
		APP_WEST  = 2'd3
	} approach_t;

	localparam int NUM_APPROACH = 4;

	// ------------------------------------------------------------
	// 640x480 timing, 25 MHz pixel clock
	// ------------------------------------------------------------
	localparam coord_t H_TOTAL = 10'd800;
	localparam coord_t H_PULSE = 10'd96;
	localparam coord_t H_BP    = 10'd144;
	localparam coord_t H_FP    = 10'd784;

	localparam coord_t V_TOTAL = 10'd521;
	localparam coord_t V_PULSE = 10'd2;
	localparam coord_t V_BP    = 10'd31;
	localparam coord_t V_FP    = 10'd511;

	localparam coord_t H_ACTIVE = H_FP - H_BP;
	localparam coord_t V_ACTIVE = V_FP - V_BP;

	// ------------------------------------------------------------
	// palette
	// ------------------------------------------------------------
	localparam rgb_t COLOR_BLACK   = 8'h00;
	localparam rgb_t COLOR_WHITE   = 8'hFF;
	localparam rgb_t COLOR_YELLOW  = 8'hFC;
	localparam rgb_t COLOR_CYAN    = 8'h1F;
	localparam rgb_t COLOR_GREEN   = 8'h1C;
	localparam rgb_t COLOR_MAGENTA = 8'hE3;
	localparam rgb_t COLOR_RED     = 8'hE0;
	localparam rgb_t COLOR_BLUE    = 8'h03;

	// ------------------------------------------------------------
	// scene geometry
	// ------------------------------------------------------------
	localparam coord_t ROAD_X0    = 10'd200;
	localparam coord_t ROAD_Y0    = 10'd120;
	localparam coord_t ROAD_WIDTH = 10'd240;

	localparam coord_t CAR_LONG  = 10'd60;
	localparam coord_t CAR_SHORT = 10'd30;

	// lane base positions, slow and fast car per axis
	localparam coord_t LANE_V_SLOW = 10'd275;
	localparam coord_t LANE_V_FAST = 10'd215;
	localparam coord_t LANE_H_SLOW = 10'd315;
	localparam coord_t LANE_H_FAST = 10'd255;

	// offsets at which a car waits for a red light
	localparam coord_t STOP_VERT  = 10'd60;
	localparam coord_t STOP_HORIZ = 10'd140;

	localparam coord_t STEP_SLOW = 10'd1;
	localparam coord_t STEP_FAST = 10'd2;

	// lamp corners, indexed by approach
	localparam coord_t LAMP_SIZE = 10'd15;
	localparam coord_t RED_LAMP_X [NUM_APPROACH] = '{10'd363, 10'd615, 10'd262, 10'd5};
	localparam coord_t RED_LAMP_Y [NUM_APPROACH] = '{10'd5, 10'd283, 10'd460, 10'd182};
	localparam coord_t GREEN_LAMP_X [NUM_APPROACH] = '{10'd382, 10'd615, 10'd243, 10'd5};
	localparam coord_t GREEN_LAMP_Y [NUM_APPROACH] = '{10'd5, 10'd302, 10'd460, 10'd163};

endpackage

`default_nettype wire

// ==== vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing
(
	input  wire                   dclk,
	input  wire                   clr,
	output logic                  hsync_raw,
	output logic                  vsync_raw,
	output logic                  video_on,
	output traffic_pkg::coord_t   px,
	output traffic_pkg::coord_t   py
);

	import traffic_pkg::*;

	coord_t hc;
	coord_t vc;

	// ------------------------------------------------------------
	// raster counters
	// ------------------------------------------------------------
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			hc <= '0;
			vc <= '0;
		end
		else if (hc == H_TOTAL - 10'd1)
		begin
			// end of line, step to next line
			hc <= '0;
			if (vc == V_TOTAL - 10'd1)
				vc <= '0;
			else
				vc <= vc + 10'd1;
		end
		else
		begin
			hc <= hc + 10'd1;
		end
	end

	// active low sync pulses at the start of line and frame
	assign hsync_raw = (hc >= H_PULSE);
	assign vsync_raw = (vc >= V_PULSE);

	// visible window between back and front porch
	assign video_on = (hc >= H_BP) && (hc < H_FP) && (vc >= V_BP) && (vc < V_FP);

	// coordinates relative to the top left visible pixel
	assign px = hc - H_BP;
	assign py = vc - V_BP;

endmodule

`default_nettype wire
